//--- common/conv_pkg.sv
`include "conv_settings.svh"

package conv_pkg;

        // four signed 8-bit elements per word
        typedef logic [`DATA_W-1:0] word_t;

        typedef logic [$clog2(`MEM0_DEPTH)-1:0] mem0_addr_t;
        typedef logic [$clog2(`MEM1_DEPTH)-1:0] mem1_addr_t;

        // row * PE_SIZE + lane
        typedef logic [$clog2(`PE_SIZE * `ROW_NUM)-1:0] res_addr_t;

        typedef logic [7:0] wb_addr_t;

        // sum of four 8x8 signed products
        typedef logic signed [17:0] acc_t;

        typedef enum logic [2:0] {
                IDLE,
                LOAD_W,
                GAP,
                STREAM,
                DRAIN
        } mover_state_t;

endpackage

//--- common/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// array geometry
`define PE_SIZE     4
`define ROW_NUM     16

// memory depths in words
`define MEM0_DEPTH  4
`define MEM1_DEPTH  16

// idle cycles between weight load and first activation read
`define WEIGHT_GAP  3

`define DATA_W      32

// word address region bases, region picked by adr[7:6]
`define REG_CTRL    8'h00
`define BASE_MEM0   8'h40
`define BASE_MEM1   8'h80
`define BASE_RES    8'hC0

`endif

//--- data_mover/conv_data_mover.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_data_mover
        import conv_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       start_i,
        output logic       mem0_ce_o,
        output mem0_addr_t mem0_addr_o,
        output logic       mem1_ce_o,
        output mem1_addr_t mem1_addr_o,
        output logic       w_valid_o,
        output mem0_addr_t w_idx_o,
        output logic       a_valid_o,
        output logic       busy_o,
        output logic       done_o
);

        mover_state_t state_q;
        mover_state_t state_d;

        logic       launch;
        logic       w_run;
        logic       w_done;
        logic       g_done;
        logic       s_run;
        logic       s_done;
        logic       drain_q;
        mem0_addr_t w_addr_q;
        mem1_addr_t a_addr_q;

        assign launch = start_i && (state_q == IDLE);

        // weight load window
        phase_counter #(
                .COUNT_NUM(`PE_SIZE)
        ) u_weight_phase (
                .clk     (clk),
                .rst_n   (rst_n),
                .start_i (launch),
                .run_o   (w_run),
                .done_o  (w_done)
        );

        // fixed gap after the last weight read
        phase_counter #(
                .COUNT_NUM(`WEIGHT_GAP)
        ) u_gap_phase (
                .clk     (clk),
                .rst_n   (rst_n),
                .start_i (w_done),
                .run_o   (),
                .done_o  (g_done)
        );

        // activation stream window
        phase_counter #(
                .COUNT_NUM(`ROW_NUM)
        ) u_stream_phase (
                .clk     (clk),
                .rst_n   (rst_n),
                .start_i (g_done),
                .run_o   (s_run),
                .done_o  (s_done)
        );

        always_comb begin
                state_d = state_q;
                case (state_q)
                        IDLE:    if (start_i) state_d = LOAD_W;
                        LOAD_W:  if (w_done)  state_d = GAP;
                        GAP:     if (g_done)  state_d = STREAM;
                        STREAM:  if (s_done)  state_d = DRAIN;
                        DRAIN:   if (drain_q) state_d = IDLE;
                        default: state_d = IDLE;
                endcase
        end

        // drain covers memory latency plus the lane register
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state_q <= IDLE;
                        drain_q <= 1'b0;
                end else begin
                        state_q <= state_d;
                        drain_q <= (state_q == DRAIN) && !drain_q;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        w_addr_q  <= '0;
                        a_addr_q  <= '0;
                        w_valid_o <= 1'b0;
                        w_idx_o   <= '0;
                        a_valid_o <= 1'b0;
                end else begin
                        // read data lands one cycle after ce
                        w_valid_o <= w_run;
                        w_idx_o   <= w_addr_q;
                        a_valid_o <= s_run;
                        if (launch) begin
                                w_addr_q <= '0;
                                a_addr_q <= '0;
                        end else begin
                                if (w_run) begin
                                        w_addr_q <= w_addr_q + 1'b1;
                                end
                                if (s_run) begin
                                        a_addr_q <= a_addr_q + 1'b1;
                                end
                        end
                end
        end

        assign mem0_ce_o   = w_run;
        assign mem0_addr_o = w_addr_q;
        assign mem1_ce_o   = s_run;
        assign mem1_addr_o = a_addr_q;
        assign busy_o      = (state_q != IDLE);
        assign done_o      = drain_q;

endmodule

//--- data_mover/phase_counter.sv
`timescale 1ns/1ps

module phase_counter #(
        parameter int COUNT_NUM = 4
) (
        input  logic clk,
        input  logic rst_n,
        input  logic start_i,
        output logic run_o,
        output logic done_o
);

        localparam int CW = (COUNT_NUM > 1) ? $clog2(COUNT_NUM) : 1;

        logic [CW-1:0] cnt_q;

        // last cycle of the run window
        assign done_o = run_o && (cnt_q == CW'(COUNT_NUM - 1));

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        run_o <= 1'b0;
                        cnt_q <= '0;
                end else if (start_i) begin
                        run_o <= 1'b1;
                        cnt_q <= '0;
                end else if (done_o) begin
                        run_o <= 1'b0;
                end else if (run_o) begin
                        cnt_q <= cnt_q + 1'b1;
                end
        end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_top -f sim.f

out=$(./obj_dir/Vtb_conv_top)
echo "$out"

if echo "$out" | grep -qx "Simulation completed successfully"; then
        exit 0
fi
exit 1

//--- sim.f
+incdir+common
common/conv_pkg.sv
src/tile_mem.sv
data_mover/phase_counter.sv
data_mover/conv_data_mover.sv
src/mac_lane_row.sv
src/result_buffer.sv
src/wb_host_port.sv
src/conv_top.sv
verification/tb_conv_top.sv

//--- src/conv_top.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_top
        import conv_pkg::*;
(
        input  logic     clk,
        input  logic     rst_n,
        input  logic     wb_cyc_i,
        input  logic     wb_stb_i,
        input  logic     wb_we_i,
        input  wb_addr_t wb_adr_i,
        input  word_t    wb_dat_i,
        output word_t    wb_dat_o,
        output logic     wb_ack_o
);

        logic       start;
        logic       busy;
        logic       done;
        logic       mem0_ce, mem0_we, mem1_ce, mem1_we;
        mem0_addr_t mem0_addr;
        mem1_addr_t mem1_addr;
        word_t      mem_wdata, mem0_rdata, mem1_rdata, res_rdata;
        res_addr_t  res_addr;
        logic       mv_mem0_ce, mv_mem1_ce;
        mem0_addr_t mv_mem0_addr;
        mem1_addr_t mv_mem1_addr;
        logic       w_valid, a_valid, row_valid;
        mem0_addr_t w_idx;
        acc_t       row_sum [`PE_SIZE];

        wb_host_port u_host (
                .clk(clk), .rst_n(rst_n),
                .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
                .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
                .busy_i(busy), .done_i(done),
                .mem0_rdata_i(mem0_rdata), .mem1_rdata_i(mem1_rdata), .res_rdata_i(res_rdata),
                .mv_mem0_ce_i(mv_mem0_ce), .mv_mem0_addr_i(mv_mem0_addr),
                .mv_mem1_ce_i(mv_mem1_ce), .mv_mem1_addr_i(mv_mem1_addr),
                .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .start_o(start),
                .mem0_ce_o(mem0_ce), .mem0_we_o(mem0_we), .mem0_addr_o(mem0_addr),
                .mem1_ce_o(mem1_ce), .mem1_we_o(mem1_we), .mem1_addr_o(mem1_addr),
                .mem_wdata_o(mem_wdata), .res_addr_o(res_addr)
        );

        tile_mem #(.DEPTH(`MEM0_DEPTH)) u_mem0 (
                .clk(clk), .ce_i(mem0_ce), .we_i(mem0_we), .addr_i(mem0_addr),
                .wdata_i(mem_wdata), .rdata_o(mem0_rdata)
        );

        tile_mem #(.DEPTH(`MEM1_DEPTH)) u_mem1 (
                .clk(clk), .ce_i(mem1_ce), .we_i(mem1_we), .addr_i(mem1_addr),
                .wdata_i(mem_wdata), .rdata_o(mem1_rdata)
        );

        conv_data_mover u_mover (
                .clk(clk), .rst_n(rst_n), .start_i(start),
                .mem0_ce_o(mv_mem0_ce), .mem0_addr_o(mv_mem0_addr),
                .mem1_ce_o(mv_mem1_ce), .mem1_addr_o(mv_mem1_addr),
                .w_valid_o(w_valid), .w_idx_o(w_idx), .a_valid_o(a_valid),
                .busy_o(busy), .done_o(done)
        );

        // read data goes straight from the memories to the lanes
        mac_lane_row u_lanes (
                .clk(clk), .rst_n(rst_n),
                .w_valid_i(w_valid), .w_idx_i(w_idx), .w_data_i(mem0_rdata),
                .a_valid_i(a_valid), .a_data_i(mem1_rdata),
                .row_valid_o(row_valid), .row_sum_o(row_sum)
        );

        result_buffer u_results (
                .clk(clk), .rst_n(rst_n), .start_i(start),
                .row_valid_i(row_valid), .row_sum_i(row_sum),
                .rd_addr_i(res_addr), .rd_data_o(res_rdata)
        );

endmodule

//--- src/mac_lane_row.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module mac_lane_row
        import conv_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       w_valid_i,
        input  mem0_addr_t w_idx_i,
        input  word_t      w_data_i,
        input  logic       a_valid_i,
        input  word_t      a_data_i,
        output logic       row_valid_o,
        output acc_t       row_sum_o [`PE_SIZE]
);

        // stationary weights, one word per lane
        word_t w_q [`PE_SIZE];

        // signed byte-wise dot product of two words
        function automatic acc_t dot_word(input word_t w, input word_t a);
                acc_t s;
                s = '0;
                for (int j = 0; j < `PE_SIZE; j++) begin
                        s = s + $signed(w[8*j +: 8]) * $signed(a[8*j +: 8]);
                end
                return s;
        endfunction

        always_ff @(posedge clk) begin
                if (w_valid_i) begin
                        w_q[w_idx_i] <= w_data_i;
                end
        end

        always_ff @(posedge clk) begin
                if (a_valid_i) begin
                        for (int k = 0; k < `PE_SIZE; k++) begin
                                row_sum_o[k] <= dot_word(w_q[k], a_data_i);
                        end
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        row_valid_o <= 1'b0;
                end else begin
                        row_valid_o <= a_valid_i;
                end
        end

endmodule

//--- src/result_buffer.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module result_buffer
        import conv_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n,
        input  logic      start_i,
        input  logic      row_valid_i,
        input  acc_t      row_sum_i [`PE_SIZE],
        input  res_addr_t rd_addr_i,
        output word_t     rd_data_o
);

        localparam int RW = $clog2(`ROW_NUM);

        acc_t          res_mem [`PE_SIZE * `ROW_NUM];
        logic [RW-1:0] row_ptr_q;
        // rows written since reset, unwritten rows read as zero
        logic [`ROW_NUM-1:0] row_seen_q;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        row_ptr_q  <= '0;
                        row_seen_q <= '0;
                end else if (start_i) begin
                        row_ptr_q <= '0;
                end else if (row_valid_i) begin
                        row_ptr_q             <= row_ptr_q + 1'b1;
                        row_seen_q[row_ptr_q] <= 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (row_valid_i) begin
                        for (int k = 0; k < `PE_SIZE; k++) begin
                                res_mem[res_addr_t'(row_ptr_q * `PE_SIZE + k)] <= row_sum_i[k];
                        end
                end
        end

        // signed source, so the cast sign-extends
        always_ff @(posedge clk) begin
                if (row_seen_q[rd_addr_i / `PE_SIZE]) begin
                        rd_data_o <= word_t'(res_mem[rd_addr_i]);
                end else begin
                        rd_data_o <= '0;
                end
        end

endmodule

//--- src/tile_mem.sv
`timescale 1ns/1ps

module tile_mem
        import conv_pkg::*;
#(
        parameter int DEPTH = 4
) (
        input  logic                     clk,
        input  logic                     ce_i,
        input  logic                     we_i,
        input  logic [$clog2(DEPTH)-1:0] addr_i,
        input  word_t                    wdata_i,
        output word_t                    rdata_o
);

        word_t mem [DEPTH];

        // read-first, data one cycle after ce
        always_ff @(posedge clk) begin
                if (ce_i) begin
                        if (we_i) begin
                                mem[addr_i] <= wdata_i;
                        end
                        rdata_o <= mem[addr_i];
                end
        end

endmodule

//--- src/wb_host_port.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module wb_host_port
        import conv_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       wb_cyc_i,
        input  logic       wb_stb_i,
        input  logic       wb_we_i,
        input  wb_addr_t   wb_adr_i,
        input  word_t      wb_dat_i,
        input  logic       busy_i,
        input  logic       done_i,
        input  word_t      mem0_rdata_i,
        input  word_t      mem1_rdata_i,
        input  word_t      res_rdata_i,
        input  logic       mv_mem0_ce_i,
        input  mem0_addr_t mv_mem0_addr_i,
        input  logic       mv_mem1_ce_i,
        input  mem1_addr_t mv_mem1_addr_i,
        output word_t      wb_dat_o,
        output logic       wb_ack_o,
        output logic       start_o,
        output logic       mem0_ce_o,
        output logic       mem0_we_o,
        output mem0_addr_t mem0_addr_o,
        output logic       mem1_ce_o,
        output logic       mem1_we_o,
        output mem1_addr_t mem1_addr_o,
        output word_t      mem_wdata_o,
        output res_addr_t  res_addr_o
);

        localparam int AW      = $bits(wb_addr_t);
        localparam int RGN_LSB = $bits(res_addr_t);

        typedef logic [AW-RGN_LSB-1:0] rgn_t;

        localparam wb_addr_t CTRL_A = `REG_CTRL;
        localparam wb_addr_t MEM0_A = `BASE_MEM0;
        localparam wb_addr_t MEM1_A = `BASE_MEM1;
        localparam wb_addr_t RES_A  = `BASE_RES;

        localparam rgn_t RGN_CTRL = CTRL_A[AW-1:RGN_LSB];
        localparam rgn_t RGN_MEM0 = MEM0_A[AW-1:RGN_LSB];
        localparam rgn_t RGN_MEM1 = MEM1_A[AW-1:RGN_LSB];
        localparam rgn_t RGN_RES  = RES_A[AW-1:RGN_LSB];

        logic req;
        rgn_t rgn;
        rgn_t rgn_q;
        logic blocked_q;
        logic done_q;
        logic host_mem0;
        logic host_mem1;

        // ack cycle masked so each request is seen once
        assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;
        assign rgn = wb_adr_i[AW-1:RGN_LSB];

        // host owns the memories only while idle
        assign host_mem0 = req && (rgn == RGN_MEM0) && !busy_i;
        assign host_mem1 = req && (rgn == RGN_MEM1) && !busy_i;

        assign mem0_ce_o   = busy_i ? mv_mem0_ce_i : host_mem0;
        assign mem0_we_o   = host_mem0 && wb_we_i;
        assign mem0_addr_o = busy_i ? mv_mem0_addr_i : wb_adr_i[$bits(mem0_addr_t)-1:0];
        assign mem1_ce_o   = busy_i ? mv_mem1_ce_i : host_mem1;
        assign mem1_we_o   = host_mem1 && wb_we_i;
        assign mem1_addr_o = busy_i ? mv_mem1_addr_i : wb_adr_i[$bits(mem1_addr_t)-1:0];
        assign mem_wdata_o = wb_dat_i;
        assign res_addr_o  = wb_adr_i[RGN_LSB-1:0];

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wb_ack_o  <= 1'b0;
                        rgn_q     <= '0;
                        blocked_q <= 1'b0;
                        start_o   <= 1'b0;
                        done_q    <= 1'b0;
                end else begin
                        wb_ack_o <= req;
                        if (req) begin
                                rgn_q     <= rgn;
                                blocked_q <= busy_i;
                        end
                        // start is dropped while a run is active
                        start_o <= req && wb_we_i && (rgn == RGN_CTRL) && wb_dat_i[0] && !busy_i;
                        if (start_o) begin
                                done_q <= 1'b0;
                        end else if (done_i) begin
                                done_q <= 1'b1;
                        end
                end
        end

        // memory data arrives in the ack cycle
        always_comb begin
                wb_dat_o = '0;
                case (rgn_q)
                        RGN_CTRL: wb_dat_o = {{(`DATA_W - 2){1'b0}}, done_q, busy_i};
                        RGN_MEM0: wb_dat_o = blocked_q ? '0 : mem0_rdata_i;
                        RGN_MEM1: wb_dat_o = blocked_q ? '0 : mem1_rdata_i;
                        RGN_RES:  wb_dat_o = res_rdata_i;
                        default:  wb_dat_o = '0;
                endcase
        end

endmodule

//--- verification/conv_cases.txt
// columns: op address data, all hex, address is the wishbone word address
// op 0 write, 1 read and compare, 2 start and wait for done, f end of list
0 40 01010101
0 41 000000ff
0 42 7f000000
0 43 80808080
0 80 04030201
0 81 fffefdfc
0 82 7f7f7f7f
0 83 00000000
0 84 12345678
0 85 87654321
0 86 01ff01ff
0 87 80000001
0 88 0a0b0c0d
0 89 f0e0d0c0
0 8a 55aa55aa
0 8b 00ff7f80
0 8c 11111111
0 8d c3c3c3c3
0 8e 7f80017f
0 8f 80808080
1 42 7f000000
1 8f 80808080
2 00 00000000
1 c0 0000000a
1 c1 ffffffff
1 c2 000001fc
1 c3 fffffb00
1 fc fffffe00
1 fd 00000080
1 fe ffffc080
1 ff 00010000
1 00 00000002
f 00 00000000

//--- verification/tb_conv_top.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module tb_conv_top;

        localparam int RUN_CYC  = `PE_SIZE + `WEIGHT_GAP + `ROW_NUM + 2;
        localparam int RES_NUM  = `PE_SIZE * `ROW_NUM;
        // worst test loads both memories and reads every result
        localparam int BUS_OPS  = 5 * (`MEM0_DEPTH + `MEM1_DEPTH + RES_NUM);
        localparam int LIMIT    = 10 * (2 * BUS_OPS + 4 * RUN_CYC);
        localparam int CASE_MAX = 64;

        logic        clk;
        logic        rst_n;
        logic        wb_cyc;
        logic        wb_stb;
        logic        wb_we;
        logic [7:0]  wb_adr;
        logic [31:0] wb_dat_w;
        logic [31:0] wb_dat_r;
        logic        wb_ack;

        // host view of both memories
        logic [31:0] w_model [`MEM0_DEPTH];
        logic [31:0] a_model [`MEM1_DEPTH];
        logic [31:0] case_mem [3 * CASE_MAX];
        logic [31:0] rng;
        int          cycles = 0;
        int          run_start;
        int          test_err;
        int          total_err;
        int          tests_run;
        int          tests_failed;

        conv_top conv_top_inst (
                .clk      (clk),
                .rst_n    (rst_n),
                .wb_cyc_i (wb_cyc),
                .wb_stb_i (wb_stb),
                .wb_we_i  (wb_we),
                .wb_adr_i (wb_adr),
                .wb_dat_i (wb_dat_w),
                .wb_dat_o (wb_dat_r),
                .wb_ack_o (wb_ack)
        );

        always #2 clk = ~clk;

        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles > LIMIT) begin
                        $display("timeout, run stopped after %0d cycles", cycles);
                        $display("Simulation failed");
                        $finish;
                end
        end

        function automatic logic [31:0] xorshift(input logic [31:0] s);
                logic [31:0] x;
                x = s;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        // signed byte dot product of one weight word and one activation word
        function automatic logic [31:0] lane_sum(input logic [31:0] w, input logic [31:0] a);
                int s;
                s = 0;
                for (int j = 0; j < `PE_SIZE; j++) begin
                        s = s + int'($signed(w[8*j +: 8])) * int'($signed(a[8*j +: 8]));
                end
                return s;
        endfunction

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                assert (got === exp) else begin
                        $display("mismatch %s: got %h expected %h", name, got, exp);
                        test_err++;
                end
        endtask

        // one classic cycle with inputs changed 1 ns after the edge
        task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                                 output logic [31:0] rdata);
                int wait_cyc;
                @(posedge clk);
                #1;
                wb_cyc   = 1'b1;
                wb_stb   = 1'b1;
                wb_we    = we;
                wb_adr   = adr;
                wb_dat_w = wdata;
                wait_cyc = 0;
                do begin
                        @(posedge clk);
                        #1;
                        wait_cyc++;
                end while (!wb_ack && wait_cyc < 8);
                assert (wb_ack) else begin
                        $display("no ack from the bus for address %h", adr);
                        test_err++;
                end
                rdata  = wb_dat_r;
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
                wb_we  = 1'b0;
        endtask

        task automatic bus_write(input logic [7:0] adr, input logic [31:0] data);
                logic [31:0] unused;
                bus_cycle(1'b1, adr, data, unused);
        endtask

        task automatic read_expect(input logic [7:0] adr, input logic [31:0] exp);
                logic [31:0] got;
                bus_cycle(1'b0, adr, 32'h0, got);
                check_value($sformatf("wb_dat_o at %02h", adr), got, exp);
        endtask

        task automatic mem_write(input logic [7:0] adr, input logic [31:0] data);
                bus_write(adr, data);
                if ((adr & 8'hC0) == `BASE_MEM0) begin
                        w_model[adr[1:0]] = data;
                end else if ((adr & 8'hC0) == `BASE_MEM1) begin
                        a_model[adr[3:0]] = data;
                end
        endtask

        task automatic start_run();
                bus_write(`REG_CTRL, 32'h1);
        endtask

        // poll status until busy drops and expect done set
        task automatic wait_done();
                logic [31:0] st;
                int polls;
                polls = 0;
                do begin
                        bus_cycle(1'b0, `REG_CTRL, 32'h0, st);
                        polls++;
                end while (st[0] && polls < 2 * RUN_CYC);
                assert (!st[0]) else begin
                        $display("run did not finish within %0d status reads", polls);
                        test_err++;
                end
                check_value("done bit", {31'h0, st[1]}, 32'h1);
        endtask

        task automatic check_results();
                logic [7:0] adr;
                for (int r = 0; r < `ROW_NUM; r++) begin
                        for (int k = 0; k < `PE_SIZE; k++) begin
                                adr = `BASE_RES + 8'(r * `PE_SIZE + k);
                                read_expect(adr, lane_sum(w_model[k], a_model[r]));
                        end
                end
        endtask

        task automatic load_random();
                for (int i = 0; i < `MEM0_DEPTH; i++) begin
                        rng = xorshift(rng);
                        mem_write(`BASE_MEM0 + 8'(i), rng);
                end
                for (int i = 0; i < `MEM1_DEPTH; i++) begin
                        rng = xorshift(rng);
                        mem_write(`BASE_MEM1 + 8'(i), rng);
                end
        endtask

        // records of op address and data
        task automatic run_cases();
                logic [31:0] op;
                int i;
                for (int n = 0; n < 3 * CASE_MAX; n++) begin
                        case_mem[n] = 32'hf;
                end
                $readmemh("verification/conv_cases.txt", case_mem);
                i = 0;
                while (i < CASE_MAX && case_mem[3*i] != 32'hf) begin
                        op = case_mem[3*i];
                        case (op)
                                32'h0: mem_write(case_mem[3*i+1][7:0], case_mem[3*i+2]);
                                32'h1: read_expect(case_mem[3*i+1][7:0], case_mem[3*i+2]);
                                32'h2: begin
                                        start_run();
                                        wait_done();
                                end
                                default: begin
                                        $display("unknown case operation %h in record %0d", op, i);
                                        test_err++;
                                end
                        endcase
                        i++;
                end
        endtask

        task automatic finish_test(input string name);
                tests_run++;
                if (test_err == 0) begin
                        $display("test %s: ok", name);
                end else begin
                        $display("test %s: %0d errors", name, test_err);
                        tests_failed++;
                end
                total_err += test_err;
                test_err = 0;
        endtask

        initial begin
                clk          = 1'b0;
                rst_n        = 1'b0;
                wb_cyc       = 1'b0;
                wb_stb       = 1'b0;
                wb_we        = 1'b0;
                wb_adr       = 8'h0;
                wb_dat_w     = 32'h0;
                rng          = 32'h6c95;
                run_start    = 0;
                test_err     = 0;
                total_err    = 0;
                tests_run    = 0;
                tests_failed = 0;
                repeat (2) @(posedge clk);
                #1;
                rst_n = 1'b1;

                read_expect(`REG_CTRL, 32'h0);
                read_expect(`BASE_RES, 32'h0);
                read_expect(`BASE_RES + 8'(RES_NUM - 1), 32'h0);
                finish_test("reset state");

                run_cases();
                check_results();
                finish_test("directed cases");

                // mem0 write while busy must be dropped
                start_run();
                bus_write(`BASE_MEM0, ~w_model[0]);
                wait_done();
                read_expect(`BASE_MEM0, w_model[0]);
                check_results();
                finish_test("write during run");

                load_random();
                start_run();
                read_expect(`REG_CTRL, 32'h1);
                wait_done();
                check_results();
                finish_test("random restart");

                // second start lands in the activation stream
                load_random();
                start_run();
                run_start = cycles;
                repeat (4) read_expect(`REG_CTRL, 32'h1);
                start_run();
                wait_done();
                // one run plus at most two cycles of status polling
                assert (cycles - run_start <= RUN_CYC + 2) else begin
                        $display("run ended %0d cycles after its start, longer than one run",
                                 cycles - run_start);
                        test_err++;
                end
                check_results();
                finish_test("start while busy");

                $display("tests run %0d, tests failed %0d, checks failed %0d",
                         tests_run, tests_failed, total_err);
                if (total_err == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule
